// File: common/tdc_pkg.sv
package tdc_pkg;

    // --------------------
    // widths
    // --------------------
    localparam int WORD_W         = 32;
    localparam int BYTE_W         = 8;
    localparam int BYTES_PER_WORD = 4;

    // coarse time stamp, one clkWizard tick per lsb
    typedef logic [WORD_W-1:0] stamp_t;

    // stamper to fifo, valid is a single-cycle strobe
    typedef struct packed {
        logic   valid;
        stamp_t stamp;
    } hit_event_t;

    // fifo flags, overflow is sticky until reset
    typedef struct packed {
        logic full;
        logic empty;
        logic overflow;
    } fifo_status_t;

    // --------------------
    // state encodings
    // --------------------
    typedef enum logic [1:0] {
        ST_WAIT  = 2'd0,
        ST_WRITE = 2'd1,
        ST_READ  = 2'd2
    } ctrl_state_e;

    typedef enum logic [1:0] {
        TX_IDLE  = 2'd0,
        TX_START = 2'd1,
        TX_DATA  = 2'd2,
        TX_STOP  = 2'd3
    } tx_state_e;

endpackage

// File: fifo/word_fifo.sv
`timescale 1ns/1ns

module word_fifo #(
    parameter int FIFO_DEPTH = 1024
) (
    input  logic                  clkWizard,
    input  logic                  finish_mem_reset,
    input  tdc_pkg::hit_event_t   hit_evt,
    input  logic                  pop,
    output tdc_pkg::stamp_t       rd_word,
    output tdc_pkg::fifo_status_t status
);

    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    // stamp storage
    tdc_pkg::stamp_t mem [FIFO_DEPTH];

    // pointers carry one extra wrap bit
    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] rd_ptr;
    logic            full;
    logic            empty;
    logic            overflow_q;
    logic            push;

    // --------------------
    // flags
    // --------------------
    assign empty = (wr_ptr == rd_ptr);
    // same address, opposite wrap bit
    assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                   (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    // drop the stamp when full
    assign push  = hit_evt.valid && !full;

    // --------------------
    // write side
    // --------------------
    always_ff @(posedge clkWizard) begin
        if (push) begin
            mem[wr_ptr[ADDR_W-1:0]] <= hit_evt.stamp;
        end
    end

    always_ff @(posedge clkWizard) begin
        if (finish_mem_reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            overflow_q <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + (ADDR_W+1)'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + (ADDR_W+1)'(1);
            end
            // sticky until reset
            if (hit_evt.valid && full) begin
                overflow_q <= 1'b1;
            end
        end
    end

    // --------------------
    // read side
    // --------------------
    // first word fall through, head always visible
    assign rd_word = mem[rd_ptr[ADDR_W-1:0]];

    assign status = '{full: full, empty: empty, overflow: overflow_q};

    // reader must check empty before popping
    a_no_pop_empty : assert property (
        @(posedge clkWizard) disable iff (finish_mem_reset)
        pop |-> !empty
    );

endmodule

// File: flist.f
common/tdc_pkg.sv
src/readout_ctrl.sv
tdc/hit_timestamper.sv
fifo/word_fifo.sv
uart/uart_tx.sv
uart/byte_sender.sv
src/tdc_readout_top.sv
verif/tb_tdc_readout.sv

// File: run.sh
#!/usr/bin/env bash
# build the readout testbench with verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
    --top-module tb_tdc_readout \
    -f flist.f \
    -o tb_tdc_readout
./obj_dir/tb_tdc_readout

// File: src/readout_ctrl.sv
`timescale 1ns/1ns

module readout_ctrl (
    input  logic clkWizard,
    input  logic finish_mem_reset,
    input  logic start_write,
    input  logic start_read,
    output logic write_enable,
    output logic read_enable,
    output logic led_write_stage,
    output logic led_read_stage
);

    tdc_pkg::ctrl_state_e state_q;
    tdc_pkg::ctrl_state_e state_d;

    // --------------------
    // next state
    // --------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            tdc_pkg::ST_WAIT: begin
                // write button wins if both pressed
                if (start_write) begin
                    state_d = tdc_pkg::ST_WRITE;
                end else if (start_read) begin
                    state_d = tdc_pkg::ST_READ;
                end
            end
            tdc_pkg::ST_WRITE: begin
                if (start_read) begin
                    state_d = tdc_pkg::ST_READ;
                end
            end
            tdc_pkg::ST_READ: begin
                // write button only parks the board
                if (start_write) begin
                    state_d = tdc_pkg::ST_WAIT;
                end
            end
            default: begin
                state_d = tdc_pkg::ST_WAIT;
            end
        endcase
    end

    // --------------------
    // state and enables
    // --------------------
    always_ff @(posedge clkWizard) begin
        if (finish_mem_reset) begin
            state_q      <= tdc_pkg::ST_WAIT;
            write_enable <= 1'b0;
            read_enable  <= 1'b0;
        end else begin
            state_q      <= state_d;
            // decoded from next state so enables line up with state_q
            write_enable <= (state_d == tdc_pkg::ST_WRITE);
            read_enable  <= (state_d == tdc_pkg::ST_READ);
        end
    end

    // stage leds mirror the enables
    assign led_write_stage = write_enable;
    assign led_read_stage  = read_enable;

    // writing never overlaps reading nor follows it directly
    a_enables_exclusive : assert property (
        @(posedge clkWizard) disable iff (finish_mem_reset)
        !(write_enable && (read_enable || $past(read_enable)))
    );

endmodule

// File: src/tdc_readout_top.sv
`timescale 1ns/1ns

module tdc_readout_top #(
    parameter int FIFO_DEPTH   = 1024,
    parameter int READ_LIMIT   = 1024,
    parameter int CLKS_PER_BIT = 64
) (
    input  logic clkWizard,
    input  logic finish_mem_reset,
    input  logic hit,
    input  logic start_write,
    input  logic start_read,
    output logic tx,
    output logic led_write_stage,
    output logic led_read_stage,
    output logic led_write_err
);

    logic                        write_enable;
    logic                        read_enable;
    tdc_pkg::hit_event_t         hit_evt;
    tdc_pkg::stamp_t             rd_word;
    tdc_pkg::fifo_status_t       fifo_status;
    logic                        pop;
    logic                        tx_start;
    logic [tdc_pkg::BYTE_W-1:0]  tx_byte;
    logic                        busy;

    // --------------------
    // control
    // --------------------
    readout_ctrl u_ctrl (
        .clkWizard        (clkWizard),
        .finish_mem_reset (finish_mem_reset),
        .start_write      (start_write),
        .start_read       (start_read),
        .write_enable     (write_enable),
        .read_enable      (read_enable),
        .led_write_stage  (led_write_stage),
        .led_read_stage   (led_read_stage)
    );

    // --------------------
    // producer
    // --------------------
    hit_timestamper u_stamper (
        .clkWizard        (clkWizard),
        .finish_mem_reset (finish_mem_reset),
        .hit              (hit),
        .write_enable     (write_enable),
        .hit_evt          (hit_evt)
    );

    // stamp buffer
    word_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clkWizard        (clkWizard),
        .finish_mem_reset (finish_mem_reset),
        .hit_evt          (hit_evt),
        .pop              (pop),
        .rd_word          (rd_word),
        .status           (fifo_status)
    );

    // --------------------
    // consumer
    // --------------------
    byte_sender #(
        .READ_LIMIT (READ_LIMIT)
    ) u_sender (
        .clkWizard        (clkWizard),
        .finish_mem_reset (finish_mem_reset),
        .read_enable      (read_enable),
        .rd_word          (rd_word),
        .status           (fifo_status),
        .busy             (busy),
        .pop              (pop),
        .tx_start         (tx_start),
        .tx_byte          (tx_byte)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_uart (
        .clkWizard        (clkWizard),
        .finish_mem_reset (finish_mem_reset),
        .tx_start         (tx_start),
        .tx_byte          (tx_byte),
        .busy             (busy),
        .tx               (tx)
    );

    // lost stamp indicator
    assign led_write_err = fifo_status.overflow;

endmodule

// File: tdc/hit_timestamper.sv
`timescale 1ns/1ns

module hit_timestamper (
    input  logic                clkWizard,
    input  logic                finish_mem_reset,
    input  logic                hit,
    input  logic                write_enable,
    output tdc_pkg::hit_event_t hit_evt
);

    // --------------------
    // hit synchronizer
    // --------------------
    logic hit_meta;
    logic hit_sync;
    logic hit_sync_d;
    logic rise_q;

    // coarse counter and event payload
    tdc_pkg::stamp_t coarse_cnt;
    tdc_pkg::stamp_t evt_stamp;
    logic            evt_valid;

    always_ff @(posedge clkWizard) begin
        if (finish_mem_reset) begin
            hit_meta   <= 1'b0;
            hit_sync   <= 1'b0;
            hit_sync_d <= 1'b0;
            rise_q     <= 1'b0;
        end else begin
            // edge 0 samples hit, edge 1 second flop
            hit_meta   <= hit;
            hit_sync   <= hit_meta;
            // edge 2 registers the rising edge
            hit_sync_d <= hit_sync;
            rise_q     <= hit_sync & ~hit_sync_d;
        end
    end

    // free running, wraps silently
    always_ff @(posedge clkWizard) begin
        if (finish_mem_reset) begin
            coarse_cnt <= '0;
        end else begin
            coarse_cnt <= coarse_cnt + tdc_pkg::WORD_W'(1);
        end
    end

    // --------------------
    // event register
    // --------------------
    // edge 3 strobes valid, fifo writes on edge 4
    always_ff @(posedge clkWizard) begin
        if (finish_mem_reset) begin
            evt_valid <= 1'b0;
        end else begin
            // edges outside the writing state are dropped here
            evt_valid <= rise_q & write_enable;
        end
    end

    always_ff @(posedge clkWizard) begin
        if (rise_q) begin
            evt_stamp <= coarse_cnt;
        end
    end

    assign hit_evt = '{valid: evt_valid, stamp: evt_stamp};

endmodule

// File: uart/byte_sender.sv
`timescale 1ns/1ns

module byte_sender #(
    parameter int READ_LIMIT = 1024
) (
    input  logic                       clkWizard,
    input  logic                       finish_mem_reset,
    input  logic                       read_enable,
    input  tdc_pkg::stamp_t            rd_word,
    input  tdc_pkg::fifo_status_t      status,
    input  logic                       busy,
    output logic                       pop,
    output logic                       tx_start,
    output logic [tdc_pkg::BYTE_W-1:0] tx_byte
);

    localparam int CNT_W = $clog2(READ_LIMIT + 1);
    localparam int IDX_W = $clog2(tdc_pkg::BYTES_PER_WORD);

    tdc_pkg::stamp_t  word_q;
    logic             word_held;
    logic [IDX_W-1:0] byte_idx;
    logic [CNT_W-1:0] sent_count;
    logic             load;
    logic             send;

    // --------------------
    // fetch and send conditions
    // --------------------
    // fetch only with an empty hand and below the limit
    assign load = read_enable && !status.empty && !word_held &&
                  (sent_count < CNT_W'(READ_LIMIT));
    assign pop  = load;
    // busy lags tx_start by a cycle, so skip the cycle after a start
    assign send = word_held && read_enable && !busy && !tx_start;

    always_ff @(posedge clkWizard) begin
        if (finish_mem_reset) begin
            word_held  <= 1'b0;
            byte_idx   <= '0;
            sent_count <= '0;
            tx_start   <= 1'b0;
        end else begin
            tx_start <= send;
            if (load) begin
                word_held <= 1'b1;
                byte_idx  <= '0;
            end else if (send) begin
                byte_idx <= byte_idx + IDX_W'(1);
                // last byte handed over, word done
                if (byte_idx == IDX_W'(tdc_pkg::BYTES_PER_WORD - 1)) begin
                    word_held  <= 1'b0;
                    sent_count <= sent_count + CNT_W'(1);
                end
            end
        end
    end

    // payload registers
    always_ff @(posedge clkWizard) begin
        if (load) begin
            word_q <= rd_word;
        end
        if (send) begin
            // lsb first
            tx_byte <= word_q[byte_idx*tdc_pkg::BYTE_W +: tdc_pkg::BYTE_W];
        end
    end

    a_start_not_busy : assert property (
        @(posedge clkWizard) disable iff (finish_mem_reset)
        tx_start |-> !busy
    );

endmodule

// File: uart/uart_tx.sv
`timescale 1ns/1ns

module uart_tx #(
    parameter int CLKS_PER_BIT = 64
) (
    input  logic                       clkWizard,
    input  logic                       finish_mem_reset,
    input  logic                       tx_start,
    input  logic [tdc_pkg::BYTE_W-1:0] tx_byte,
    output logic                       busy,
    output logic                       tx
);

    localparam int DIV_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam int BIT_W = $clog2(tdc_pkg::BYTE_W);

    tdc_pkg::tx_state_e          state_q;
    logic [DIV_W-1:0]            div_cnt;
    logic [BIT_W-1:0]            bit_idx;
    logic [tdc_pkg::BYTE_W-1:0]  shift_q;
    logic                        bit_done;

    // end of the current bit period
    assign bit_done = (div_cnt == DIV_W'(CLKS_PER_BIT - 1));

    // --------------------
    // 8N1 state machine
    // --------------------
    always_ff @(posedge clkWizard) begin
        if (finish_mem_reset) begin
            state_q <= tdc_pkg::TX_IDLE;
            div_cnt <= '0;
            bit_idx <= '0;
            busy    <= 1'b0;
            tx      <= 1'b1;
        end else begin
            // divider only runs inside a frame
            if (state_q == tdc_pkg::TX_IDLE || bit_done) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + DIV_W'(1);
            end
            case (state_q)
                tdc_pkg::TX_IDLE: begin
                    if (tx_start) begin
                        state_q <= tdc_pkg::TX_START;
                        busy    <= 1'b1;
                        tx      <= 1'b0;
                    end
                end
                tdc_pkg::TX_START: begin
                    if (bit_done) begin
                        state_q <= tdc_pkg::TX_DATA;
                        bit_idx <= '0;
                        tx      <= shift_q[0];
                    end
                end
                tdc_pkg::TX_DATA: begin
                    if (bit_done) begin
                        if (bit_idx == BIT_W'(tdc_pkg::BYTE_W - 1)) begin
                            state_q <= tdc_pkg::TX_STOP;
                            tx      <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + BIT_W'(1);
                            tx      <= shift_q[1];
                        end
                    end
                end
                tdc_pkg::TX_STOP: begin
                    // busy falls at end of stop bit
                    if (bit_done) begin
                        state_q <= tdc_pkg::TX_IDLE;
                        busy    <= 1'b0;
                    end
                end
                default: begin
                    state_q <= tdc_pkg::TX_IDLE;
                end
            endcase
        end
    end

    // shifter, loaded on start, lsb goes out first
    always_ff @(posedge clkWizard) begin
        if (state_q == tdc_pkg::TX_IDLE && tx_start) begin
            shift_q <= tx_byte;
        end else if (state_q == tdc_pkg::TX_DATA && bit_done) begin
            shift_q <= {1'b0, shift_q[tdc_pkg::BYTE_W-1:1]};
        end
    end

endmodule

// File: verif/tb_tdc_readout.sv
`timescale 1ns/1ns

module tb_tdc_readout;

    localparam int FIFO_DEPTH   = 8;
    localparam int READ_LIMIT   = 12;
    localparam int CLKS_PER_BIT = 8;
    // every hit of the run, widest random gap
    localparam int N_HITS       = 17;
    localparam int MAX_GAP      = 18;
    localparam int FRAME_CYCLES = 10 * CLKS_PER_BIT;
    localparam int TIMEOUT      = 2 * N_HITS * MAX_GAP +
                                  17 * tdc_pkg::BYTES_PER_WORD * FRAME_CYCLES;

    logic clkWizard;
    logic finish_mem_reset;
    logic hit;
    logic start_write;
    logic start_read;
    logic tx;
    logic led_write_stage;
    logic led_read_stage;
    logic led_write_err;

    // --------------------
    // model state
    // --------------------
    logic [31:0]          cycle;
    logic                 reset_done;
    logic [15:0]          lfsr_state;
    tdc_pkg::ctrl_state_e model_state;
    logic                 model_overflow;
    // hit cycles of stamps still held in the fifo
    logic [31:0]          model_q[$];
    int                   rx_count;
    logic [31:0]          prev_word;
    logic [31:0]          prev_cycle;

    tdc_readout_top #(
        .FIFO_DEPTH   (FIFO_DEPTH),
        .READ_LIMIT   (READ_LIMIT),
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) tdc_readout_top_inst (
        .clkWizard        (clkWizard),
        .finish_mem_reset (finish_mem_reset),
        .hit              (hit),
        .start_write      (start_write),
        .start_read       (start_read),
        .tx               (tx),
        .led_write_stage  (led_write_stage),
        .led_read_stage   (led_read_stage),
        .led_write_err    (led_write_err)
    );

    task automatic stop_on_failure();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("ERR %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    // 16 bit fibonacci lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    // inputs change 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge clkWizard);
        #2;
    endtask

    // one-cycle button pulse, then compare leds with the model
    task automatic press_button(input logic wr);
        if (wr) begin
            start_write = 1'b1;
            if (model_state == tdc_pkg::ST_WAIT) begin
                model_state = tdc_pkg::ST_WRITE;
            end else if (model_state == tdc_pkg::ST_READ) begin
                model_state = tdc_pkg::ST_WAIT;
            end
        end else begin
            start_read = 1'b1;
            model_state = tdc_pkg::ST_READ;
        end
        next_cycle();
        start_write = 1'b0;
        start_read  = 1'b0;
        check_value(32'(led_write_stage), 32'(model_state == tdc_pkg::ST_WRITE), "write led");
        check_value(32'(led_read_stage), 32'(model_state == tdc_pkg::ST_READ), "read led");
    endtask

    // single-cycle hit, then a random gap of 3 to 18 cycles
    task automatic send_hit();
        logic [31:0] gap;
        draw_bits(4, gap);
        gap = gap + 32'd3;
        hit = 1'b1;
        if (model_state == tdc_pkg::ST_WRITE) begin
            // full fifo drops the stamp
            if (model_q.size() < FIFO_DEPTH) begin
                model_q.push_back(cycle);
            end else begin
                model_overflow = 1'b1;
            end
        end
        next_cycle();
        hit = 1'b0;
        repeat (gap - 1) next_cycle();
    endtask

    task automatic idle_check(input int n);
        repeat (n) begin
            next_cycle();
            check_value(32'(tx), 32'd1, "tx not idle");
        end
    endtask

    task automatic wait_words(input int n);
        while (rx_count < n) begin
            next_cycle();
        end
    endtask

    // rebuilt word against the oldest stored hit
    task automatic accept_word(input logic [31:0] word);
        logic [31:0] exp_cycle;
        if (model_q.size() == 0) begin
            $display("a word came out of the UART with no stored stamp left in the model");
            stop_on_failure();
        end else begin
            exp_cycle = model_q.pop_front();
            // fixed latency, so spacing of stamps equals spacing of hits
            if (rx_count > 0) begin
                check_value(word - prev_word, exp_cycle - prev_cycle, "stamp spacing");
            end
            prev_word  = word;
            prev_cycle = exp_cycle;
            rx_count   = rx_count + 1;
        end
    endtask

    // --------------------
    // clock and watchdog
    // --------------------
    initial begin
        clkWizard = 1'b0;
        forever #20 clkWizard = ~clkWizard;
    end

    initial begin
        cycle = '0;
        forever begin
            @(posedge clkWizard);
            cycle = cycle + 32'd1;
            if (cycle >= TIMEOUT) begin
                $display("timeout after %0d cycles, the DUT stopped making progress", cycle);
                stop_on_failure();
            end
        end
    end

    // sticky error led, once high never low
    initial begin : err_led_monitor
        logic seen;
        seen = 1'b0;
        wait (reset_done);
        forever begin
            @(negedge clkWizard);
            if (seen) begin
                check_value(32'(led_write_err), 32'd1, "write error led fell");
            end
            seen = seen | led_write_err;
        end
    end

    // --------------------
    // serial receiver
    // --------------------
    // samples on the falling edge, mid bit
    initial begin : serial_rx
        logic [7:0]  rx_byte;
        logic [31:0] rx_word;
        int          nbytes;
        nbytes  = 0;
        rx_word = '0;
        wait (reset_done);
        forever begin
            @(negedge clkWizard);
            if (tx === 1'b0) begin
                check_value(32'(model_state == tdc_pkg::ST_READ), 32'd1, "frame outside read");
                repeat (CLKS_PER_BIT / 2) @(negedge clkWizard);
                check_value(32'(tx), 32'd0, "start bit");
                for (int b = 0; b < tdc_pkg::BYTE_W; b++) begin
                    repeat (CLKS_PER_BIT) @(negedge clkWizard);
                    rx_byte[b] = tx;
                end
                repeat (CLKS_PER_BIT) @(negedge clkWizard);
                check_value(32'(tx), 32'd1, "stop bit");
                // least significant byte arrives first
                rx_word[nbytes*tdc_pkg::BYTE_W +: tdc_pkg::BYTE_W] = rx_byte;
                nbytes = nbytes + 1;
                if (nbytes == tdc_pkg::BYTES_PER_WORD) begin
                    nbytes = 0;
                    accept_word(rx_word);
                end
            end
        end
    end

    // --------------------
    // test sequence
    // --------------------
    initial begin
        finish_mem_reset = 1'b1;
        hit              = 1'b0;
        start_write      = 1'b0;
        start_read       = 1'b0;
        reset_done       = 1'b0;
        lfsr_state       = 16'd12273;
        model_state      = tdc_pkg::ST_WAIT;
        model_overflow   = 1'b0;
        rx_count         = 0;
        prev_word        = '0;
        prev_cycle       = '0;
        repeat (5) @(posedge clkWizard);
        #2;
        finish_mem_reset = 1'b0;
        reset_done       = 1'b1;

        // idle after reset
        check_value(32'(tx), 32'd1, "tx after reset");
        check_value(32'(led_write_stage), 32'd0, "write led after reset");
        check_value(32'(led_read_stage), 32'd0, "read led after reset");
        check_value(32'(led_write_err), 32'd0, "error led after reset");
        idle_check(20);

        // hits while waiting and while reading must not be stored
        send_hit();
        repeat (6) next_cycle();
        press_button(1'b0);
        send_hit();
        repeat (6) next_cycle();
        press_button(1'b1);
        press_button(1'b1);
        // write button inside writing keeps the state
        press_button(1'b1);

        // first session, 5 hits then read
        repeat (5) send_hit();
        repeat (6) next_cycle();
        check_value(32'(led_write_err), 32'(model_overflow), "error led after first session");
        press_button(1'b0);
        wait_words(5);
        press_button(1'b1);
        press_button(1'b1);

        // second session overfills the fifo
        repeat (10) send_hit();
        repeat (6) next_cycle();
        check_value(32'(led_write_err), 32'(model_overflow), "error led after overflow");
        press_button(1'b0);
        wait_words(READ_LIMIT);
        idle_check(1000);
        check_value(32'(led_write_err), 32'd1, "error led at end");

        $display("NO ERRORS");
        $finish;
    end

endmodule
